/* design/rvc_consts.svh */
// ####################################################################
// Fixed widths and register numbers for the RVC decompressor.
// Include this in any file that needs them; the guard keeps repeat
// includes harmless.
// ####################################################################
`ifndef RVC_CONSTS_SVH
`define RVC_CONSTS_SVH

// full and compressed instruction widths
`define RVC_ILEN 32
`define RVC_CLEN 16

// architectural registers with a fixed role in the expansions
`define RVC_REG_ZERO 5'd0
`define RVC_REG_RA 5'd1
`define RVC_REG_SP 5'd2

// high bits that widen a 3-bit register to x8..x15
`define RVC_CREG_PREFIX 2'b01

// low bits of a word that is already 32-bit
`define RVC_QUAD_FULL 2'b11

`endif

/* design/rvc_pkg.sv */
// ####################################################################
// Shared types for the RVC decompressor: instruction vectors, the
// opcode and format enums and the decoded-fields struct that the
// quadrant decoders hand to the format encoder.
// ####################################################################
`include "rvc_consts.svh"

package rvc_pkg;

	typedef logic [`RVC_ILEN-1:0] instr_t;
	typedef logic [`RVC_CLEN-1:0] cinstr_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [2:0] creg_idx_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;
	// right aligned, I/S/B take the low 12 bits
	typedef logic [19:0] imm_t;

	// major opcodes, bits 6:2 of the full word
	typedef enum logic [4:0] {
		OPC_LOAD   = 5'b00000,
		OPC_OP_IMM = 5'b00100,
		OPC_STORE  = 5'b01000,
		OPC_OP     = 5'b01100,
		OPC_LUI    = 5'b01101,
		OPC_BRANCH = 5'b11000,
		OPC_JALR   = 5'b11001,
		OPC_JAL    = 5'b11011,
		OPC_SYSTEM = 5'b11100
	} opcode_e;

	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_S,
		FMT_B,
		FMT_U,
		FMT_J
	} format_e;

	// one decoded instruction, not yet scattered into its format
	typedef struct packed {
		format_e format;
		opcode_e opcode;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		funct3_t funct3;
		funct7_t funct7;
		imm_t imm;
	} rv_fields_t;

endpackage

/* design/rvc_quadrant0_decode.sv */
// ####################################################################
// Quadrant 0 decoder (low bits 00): addi4spn, lw and sw.
// Combinational; the top level picks its result by the low bits.
// ####################################################################
`timescale 1ns/1ps
`include "rvc_consts.svh"

module rvc_quadrant0_decode (
	input  rvc_pkg::cinstr_t cinstr_i,
	output rvc_pkg::rv_fields_t fields_o,
	output logic illegal_o
);
	import rvc_pkg::*;

	creg_idx_t rs1_c;
	creg_idx_t rd_c;
	imm_t imm_word;
	imm_t imm_spn;

	// rs1' at 9:7, rd'/rs2' at 4:2
	assign rs1_c = cinstr_i[9:7];
	assign rd_c = cinstr_i[4:2];

	// word offset, zero extended and scaled by 4
	assign imm_word = {13'b0, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00};
	// nzuimm for addi4spn, also scaled by 4
	assign imm_spn = {10'b0, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5], cinstr_i[6], 2'b00};

	always_comb begin
		fields_o = '0;
		illegal_o = 1'b0;
		case (cinstr_i[15:13])
			// addi4spn, zero immediate is reserved
			3'b000: begin
				fields_o.format = FMT_I;
				fields_o.opcode = OPC_OP_IMM;
				fields_o.rd = {`RVC_CREG_PREFIX, rd_c};
				fields_o.rs1 = `RVC_REG_SP;
				fields_o.imm = imm_spn;
				illegal_o = ~|cinstr_i[12:5];
			end
			// lw
			3'b010: begin
				fields_o.format = FMT_I;
				fields_o.opcode = OPC_LOAD;
				fields_o.funct3 = 3'b010;
				fields_o.rd = {`RVC_CREG_PREFIX, rd_c};
				fields_o.rs1 = {`RVC_CREG_PREFIX, rs1_c};
				fields_o.imm = imm_word;
			end
			// sw
			3'b110: begin
				fields_o.format = FMT_S;
				fields_o.opcode = OPC_STORE;
				fields_o.funct3 = 3'b010;
				fields_o.rs1 = {`RVC_CREG_PREFIX, rs1_c};
				fields_o.rs2 = {`RVC_CREG_PREFIX, rd_c};
				fields_o.imm = imm_word;
			end
			// fp, rv64 and zcb load/store slots
			default: illegal_o = 1'b1;
		endcase
	end

endmodule

/* design/rvc_quadrant1_decode.sv */
// ####################################################################
// Quadrant 1 decoder (low bits 01): immediates, jal/j, branches,
// the register ALU forms and the Zcb ALU subset. Combinational.
// ####################################################################
`timescale 1ns/1ps
`include "rvc_consts.svh"

module rvc_quadrant1_decode (
	input  rvc_pkg::cinstr_t cinstr_i,
	output rvc_pkg::rv_fields_t fields_o,
	output logic illegal_o
);
	import rvc_pkg::*;

	reg_idx_t rd_full;
	creg_idx_t rd_c;
	creg_idx_t rs2_c;
	imm_t imm_6;
	imm_t imm_16sp;
	imm_t imm_jump;
	imm_t imm_branch;
	imm_t imm_shift;

	assign rd_full = cinstr_i[11:7];
	assign rd_c = cinstr_i[9:7];
	assign rs2_c = cinstr_i[4:2];

	// sign extended 6-bit immediate, also the lui upper bits
	assign imm_6 = {{14{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:2]};
	// stack adjust in units of 16
	assign imm_16sp = {{10{cinstr_i[12]}}, cinstr_i[12], cinstr_i[4:3], cinstr_i[5],
		cinstr_i[2], cinstr_i[6], 4'b0000};
	// jump offset bits 20:1
	assign imm_jump = {{9{cinstr_i[12]}}, cinstr_i[12], cinstr_i[8], cinstr_i[10:9],
		cinstr_i[6], cinstr_i[7], cinstr_i[2], cinstr_i[11], cinstr_i[5:3]};
	// branch offset bits 12:1
	assign imm_branch = {{12{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:5], cinstr_i[2],
		cinstr_i[11:10], cinstr_i[4:3]};
	// shamt with bit 10 picking srai
	assign imm_shift = {9'b0, cinstr_i[10], 4'b0000, cinstr_i[12], cinstr_i[6:2]};

	always_comb begin
		fields_o = '0;
		illegal_o = 1'b0;
		// defaults for the I form, the most common one here
		fields_o.format = FMT_I;
		fields_o.opcode = OPC_OP_IMM;
		fields_o.rd = {`RVC_CREG_PREFIX, rd_c};
		fields_o.rs1 = {`RVC_CREG_PREFIX, rd_c};
		fields_o.imm = imm_6;
		casez (cinstr_i[15:13])
			// addi and li, li reads x0
			3'b0?0: begin
				fields_o.rd = rd_full;
				fields_o.rs1 = cinstr_i[14] ? `RVC_REG_ZERO : rd_full;
			end
			// jal links to ra, j to x0
			3'b?01: begin
				fields_o.format = FMT_J;
				fields_o.opcode = OPC_JAL;
				fields_o.rd = cinstr_i[15] ? `RVC_REG_ZERO : `RVC_REG_RA;
				fields_o.imm = imm_jump;
			end
			// addi16sp when rd is sp, else lui
			3'b011: begin
				fields_o.rd = rd_full;
				fields_o.rs1 = rd_full;
				if (rd_full == `RVC_REG_SP) begin
					fields_o.imm = imm_16sp;
				end else begin
					fields_o.format = FMT_U;
					fields_o.opcode = OPC_LUI;
				end
			end
			3'b100: begin
				case (cinstr_i[11:10])
					// srli, srai
					2'b00, 2'b01: begin
						fields_o.funct3 = 3'b101;
						fields_o.imm = imm_shift;
					end
					// andi
					2'b10: fields_o.funct3 = 3'b111;
					default: begin
						casez ({cinstr_i[12], cinstr_i[6:5]})
							// sub, xor, or, and
							3'b0??: begin
								fields_o.format = FMT_R;
								fields_o.opcode = OPC_OP;
								fields_o.rs2 = {`RVC_CREG_PREFIX, rs2_c};
								fields_o.funct3 = {|cinstr_i[6:5], cinstr_i[6], &cinstr_i[6:5]};
								fields_o.funct7 = {1'b0, ~|cinstr_i[6:5], 5'b00000};
							end
							// zcb unary ops on rd'
							3'b111: begin
								casez (cinstr_i[4:2])
									// zext.b as andi 0xff
									3'b000: begin
										fields_o.funct3 = 3'b111;
										fields_o.imm = 20'h000ff;
									end
									// sext.b, sext.h
									3'b0?1: begin
										fields_o.funct3 = 3'b001;
										fields_o.imm = {8'b0, 11'b01100000010, cinstr_i[3]};
									end
									// zext.h
									3'b010: begin
										fields_o.format = FMT_R;
										fields_o.opcode = OPC_OP;
										fields_o.funct3 = 3'b100;
										fields_o.funct7 = 7'b0000100;
									end
									// not as xori -1
									3'b101: begin
										fields_o.funct3 = 3'b100;
										fields_o.imm = 20'h00fff;
									end
									default: illegal_o = 1'b1;
								endcase
							end
							// subw/addw and the reserved code
							default: illegal_o = 1'b1;
						endcase
					end
				endcase
			end
			// beqz, bnez against x0
			default: begin
				fields_o.format = FMT_B;
				fields_o.opcode = OPC_BRANCH;
				fields_o.rs2 = `RVC_REG_ZERO;
				fields_o.funct3 = {2'b00, cinstr_i[13]};
				fields_o.imm = imm_branch;
			end
		endcase
	end

endmodule

/* design/rvc_quadrant2_decode.sv */
// ####################################################################
// Quadrant 2 decoder (low bits 10): slli, lwsp, swsp and the
// jr/jalr/mv/add/ebreak group. Combinational.
// ####################################################################
`timescale 1ns/1ps
`include "rvc_consts.svh"

module rvc_quadrant2_decode (
	input  rvc_pkg::cinstr_t cinstr_i,
	output rvc_pkg::rv_fields_t fields_o,
	output logic illegal_o
);
	import rvc_pkg::*;

	reg_idx_t rd_full;
	reg_idx_t rs2_full;
	imm_t imm_shift;
	imm_t imm_lwsp;
	imm_t imm_swsp;

	assign rd_full = cinstr_i[11:7];
	assign rs2_full = cinstr_i[6:2];

	assign imm_shift = {14'b0, cinstr_i[12], cinstr_i[6:2]};
	// sp relative word offsets, zero extended
	assign imm_lwsp = {12'b0, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00};
	assign imm_swsp = {12'b0, cinstr_i[8:7], cinstr_i[12:9], 2'b00};

	always_comb begin
		fields_o = '0;
		illegal_o = 1'b0;
		case (cinstr_i[15:13])
			// slli
			3'b000: begin
				fields_o.format = FMT_I;
				fields_o.opcode = OPC_OP_IMM;
				fields_o.funct3 = 3'b001;
				fields_o.rd = rd_full;
				fields_o.rs1 = rd_full;
				fields_o.imm = imm_shift;
			end
			// lwsp
			3'b010: begin
				fields_o.format = FMT_I;
				fields_o.opcode = OPC_LOAD;
				fields_o.funct3 = 3'b010;
				fields_o.rd = rd_full;
				fields_o.rs1 = `RVC_REG_SP;
				fields_o.imm = imm_lwsp;
			end
			// split on nonzero rd and rs2
			3'b100: begin
				case ({|rd_full, |rs2_full})
					// jr / jalr, bit 12 selects the link
					2'b10: begin
						fields_o.format = FMT_I;
						fields_o.opcode = OPC_JALR;
						fields_o.rd = cinstr_i[12] ? `RVC_REG_RA : `RVC_REG_ZERO;
						fields_o.rs1 = rd_full;
					end
					// mv reads x0, add reads rd
					2'b11: begin
						fields_o.format = FMT_R;
						fields_o.opcode = OPC_OP;
						fields_o.rd = rd_full;
						fields_o.rs1 = cinstr_i[12] ? rd_full : `RVC_REG_ZERO;
						fields_o.rs2 = rs2_full;
					end
					// ebreak, bit 12 clear here is jr x0
					2'b00: begin
						fields_o.format = FMT_I;
						fields_o.opcode = OPC_SYSTEM;
						fields_o.imm = 20'h00001;
						illegal_o = ~cinstr_i[12];
					end
					default: illegal_o = 1'b1;
				endcase
			end
			// swsp
			3'b110: begin
				fields_o.format = FMT_S;
				fields_o.opcode = OPC_STORE;
				fields_o.funct3 = 3'b010;
				fields_o.rs1 = `RVC_REG_SP;
				fields_o.rs2 = rs2_full;
				fields_o.imm = imm_swsp;
			end
			// fp and rv64 sp forms
			default: illegal_o = 1'b1;
		endcase
	end

endmodule

/* design/rvc_format_encoder.sv */
// ####################################################################
// Scatters a decoded rv_fields_t into a 32-bit word by its format.
// Shared by all three quadrants behind the top level mux.
// ####################################################################
`timescale 1ns/1ps
`include "rvc_consts.svh"

module rvc_format_encoder (
	input  rvc_pkg::rv_fields_t fields_i,
	output rvc_pkg::instr_t instr_o
);
	import rvc_pkg::*;

	// everything above the two fixed low bits
	logic [`RVC_ILEN-1:2] body;
	imm_t imm;

	assign imm = fields_i.imm;

	always_comb begin
		case (fields_i.format)
			FMT_R: body = {fields_i.funct7, fields_i.rs2, fields_i.rs1, fields_i.funct3,
				fields_i.rd, fields_i.opcode};
			FMT_I: body = {imm[11:0], fields_i.rs1, fields_i.funct3,
				fields_i.rd, fields_i.opcode};
			FMT_S: body = {imm[11:5], fields_i.rs2, fields_i.rs1, fields_i.funct3,
				imm[4:0], fields_i.opcode};
			// imm holds offset 12:1
			FMT_B: body = {imm[11], imm[9:4], fields_i.rs2, fields_i.rs1, fields_i.funct3,
				imm[3:0], imm[10], fields_i.opcode};
			FMT_U: body = {imm, fields_i.rd, fields_i.opcode};
			// imm holds offset 20:1
			FMT_J: body = {imm[19], imm[9:0], imm[10], imm[18:11],
				fields_i.rd, fields_i.opcode};
			default: body = '0;
		endcase
	end

	assign instr_o = {body, `RVC_QUAD_FULL};

endmodule

/* design/rvc_decompressor.sv */
// ####################################################################
// RVC decompressor top level, RV32 only. Picks a quadrant decoder by
// the low two bits, passes full words through and registers the
// result once as the fetch-to-decode stage. valid_o follows valid_i
// by one cycle; there is no back-pressure.
// ####################################################################
`timescale 1ns/1ps
`include "rvc_consts.svh"

module rvc_decompressor (
	input  logic clk_i,
	input  logic reset_i,
	input  logic valid_i,
	input  rvc_pkg::instr_t instr_i,
	output logic valid_o,
	output rvc_pkg::instr_t instr_o,
	output logic is_compressed_o,
	output logic illegal_o
);
	import rvc_pkg::*;

	cinstr_t half;
	rv_fields_t q0_fields;
	rv_fields_t q1_fields;
	rv_fields_t q2_fields;
	rv_fields_t sel_fields;
	logic q0_illegal;
	logic q1_illegal;
	logic q2_illegal;
	logic sel_illegal;
	logic next_compressed;
	instr_t enc_instr;
	instr_t next_instr;

	// decoders only see the low half
	assign half = instr_i[`RVC_CLEN-1:0];

	rvc_quadrant0_decode u_q0 (
		.cinstr_i(half),
		.fields_o(q0_fields),
		.illegal_o(q0_illegal)
	);

	rvc_quadrant1_decode u_q1 (
		.cinstr_i(half),
		.fields_o(q1_fields),
		.illegal_o(q1_illegal)
	);

	rvc_quadrant2_decode u_q2 (
		.cinstr_i(half),
		.fields_o(q2_fields),
		.illegal_o(q2_illegal)
	);

	// quadrant select
	always_comb begin
		case (instr_i[1:0])
			2'b00: begin
				sel_fields = q0_fields;
				sel_illegal = q0_illegal;
			end
			2'b01: begin
				sel_fields = q1_fields;
				sel_illegal = q1_illegal;
			end
			2'b10: begin
				sel_fields = q2_fields;
				sel_illegal = q2_illegal;
			end
			// full word, encoder result is unused
			default: begin
				sel_fields = q0_fields;
				sel_illegal = 1'b0;
			end
		endcase
	end

	rvc_format_encoder u_enc (
		.fields_i(sel_fields),
		.instr_o(enc_instr)
	);

	assign next_compressed = instr_i[1:0] != `RVC_QUAD_FULL;
	assign next_instr = next_compressed ? enc_instr : instr_i;

	// fetch-to-decode register, data loads only on a strobe
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			valid_o <= 1'b0;
			instr_o <= '0;
			is_compressed_o <= 1'b0;
			illegal_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			if (valid_i) begin
				instr_o <= next_instr;
				is_compressed_o <= next_compressed;
				illegal_o <= next_compressed & sel_illegal;
			end
		end
	end

endmodule

/* testbench/rvc_decompressor_tb.sv */
// ####################################################################
// Directed testbench for the registered RVC decompressor. Each test
// is a task that strobes words into the DUT, waits for valid_o and
// compares against hand-expanded RV32 encodings.
// ####################################################################
`timescale 1ns/1ps
`include "rvc_consts.svh"

module rvc_decompressor_tb;
	import rvc_pkg::*;

	localparam int WAIT_LIMIT = 20;

	logic clk_i;
	logic reset_i;
	logic valid_i;
	instr_t instr_i;
	logic valid_o;
	instr_t instr_o;
	logic is_compressed_o;
	logic illegal_o;

	int error_count;
	int timeout_count;
	integer seed;

	rvc_decompressor dut0 (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.valid_i(valid_i),
		.instr_i(instr_i),
		.valid_o(valid_o),
		.instr_o(instr_o),
		.is_compressed_o(is_compressed_o),
		.illegal_o(illegal_o)
	);

	// 8 ns period
	always #4 clk_i = ~clk_i;

	task automatic check_instr(input string name, input instr_t exp_val, input instr_t act_val);
		if (act_val !== exp_val) begin
			$display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("FAIL %s: expected %b, actual %b", name, exp_val, act_val);
			error_count++;
		end
	endtask

	// returns on the falling edge where valid_o is seen
	task automatic wait_valid(input string name, output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clk_i);
			seen = valid_o;
			cycles++;
		end
		if (!seen) begin
			$display("%s: valid_o never came back within %0d cycles", name, WAIT_LIMIT);
			timeout_count++;
		end
	endtask

	// one strobe in, one result checked; instr check skipped for illegal words
	task automatic expand_word(input string name, input instr_t word, input instr_t exp_instr,
		input logic exp_comp, input logic exp_ill, input logic cmp_instr);
		logic seen;
		@(negedge clk_i);
		valid_i = 1'b1;
		instr_i = word;
		wait_valid(name, seen);
		valid_i = 1'b0;
		if (seen) begin
			if (cmp_instr) begin
				check_instr(name, exp_instr, instr_o);
			end
			check_flag({name, " is_compressed"}, exp_comp, is_compressed_o);
			check_flag({name, " illegal"}, exp_ill, illegal_o);
		end
	endtask

	task automatic legal_word(input string name, input instr_t word, input instr_t exp_instr);
		expand_word(name, word, exp_instr, 1'b1, 1'b0, 1'b1);
	endtask

	task automatic illegal_word(input string name, input instr_t word);
		expand_word(name, word, '0, 1'b1, 1'b1, 1'b0);
	endtask

	task automatic test_reset;
		@(negedge clk_i);
		check_flag("reset valid_o", 1'b0, valid_o);
		check_instr("reset instr_o", 32'h0000_0000, instr_o);
		check_flag("reset is_compressed_o", 1'b0, is_compressed_o);
		check_flag("reset illegal_o", 1'b0, illegal_o);
	endtask

	// valid_o one cycle after each strobe
	task automatic test_strobe_timing;
		@(negedge clk_i);
		valid_i = 1'b1;
		instr_i = 32'h0000_0013;
		@(negedge clk_i);
		valid_i = 1'b0;
		// new word without a strobe must not load
		instr_i = 32'h0010_0093;
		check_flag("pulse valid_o next", 1'b1, valid_o);
		check_instr("pulse instr_o", 32'h0000_0013, instr_o);
		@(negedge clk_i);
		check_flag("pulse valid_o after", 1'b0, valid_o);
		check_instr("hold instr_o", 32'h0000_0013, instr_o);
		// full word then c.li x5,7 on consecutive strobes
		valid_i = 1'b1;
		instr_i = 32'h0020_0113;
		@(negedge clk_i);
		instr_i = 32'h0000_429d;
		check_flag("b2b first valid", 1'b1, valid_o);
		check_instr("b2b first instr", 32'h0020_0113, instr_o);
		@(negedge clk_i);
		valid_i = 1'b0;
		check_flag("b2b second valid", 1'b1, valid_o);
		check_instr("b2b second instr", 32'h0070_0293, instr_o);
		@(negedge clk_i);
		check_flag("b2b valid drop", 1'b0, valid_o);
	endtask

	task automatic test_passthrough;
		instr_t word;
		int i;
		for (i = 0; i < 20; i++) begin
			word = $random(seed);
			word[1:0] = `RVC_QUAD_FULL;
			expand_word($sformatf("passthrough %0d", i), word, word, 1'b0, 1'b0, 1'b1);
		end
	endtask

	task automatic test_q0_q2;
		legal_word("c.addi4spn", 32'h0000_0040, 32'h0041_0413);
		legal_word("c.lw", 32'h0000_4144, 32'h0045_2483);
		legal_word("c.sw", 32'h0000_c504, 32'h0095_2423);
		legal_word("c.slli", 32'h0000_028e, 32'h0032_9293);
		legal_word("c.lwsp", 32'h0000_42a2, 32'h0081_2283);
		legal_word("c.swsp", 32'h0000_c616, 32'h0051_2623);
		legal_word("c.jr", 32'h0000_8082, 32'h0000_8067);
		legal_word("c.jalr", 32'h0000_9282, 32'h0002_80e7);
		legal_word("c.mv", 32'h0000_829a, 32'h0060_02b3);
		legal_word("c.add", 32'h0000_929a, 32'h0062_82b3);
		legal_word("c.ebreak", 32'h0000_9002, 32'h0010_0073);
	endtask

	task automatic test_q1;
		legal_word("c.addi neg", 32'h0000_12fd, 32'hfff2_8293);
		legal_word("c.li", 32'h0000_429d, 32'h0070_0293);
		legal_word("c.jal", 32'h0000_2011, 32'h0040_00ef);
		legal_word("c.addi16sp neg", 32'h0000_713d, 32'hfe01_0113);
		legal_word("c.lui", 32'h0000_6285, 32'h0000_12b7);
		legal_word("c.lui neg", 32'h0000_72fd, 32'hffff_f2b7);
		legal_word("c.srli", 32'h0000_8009, 32'h0024_5413);
		legal_word("c.srai", 32'h0000_8409, 32'h4024_5413);
		legal_word("c.andi neg", 32'h0000_987d, 32'hfff4_7413);
		legal_word("c.sub", 32'h0000_8c05, 32'h4094_0433);
		legal_word("c.xor", 32'h0000_8c25, 32'h0094_4433);
		legal_word("c.or", 32'h0000_8c45, 32'h0094_6433);
		legal_word("c.and", 32'h0000_8c65, 32'h0094_7433);
		legal_word("c.j neg", 32'h0000_bff5, 32'hffdf_f06f);
		legal_word("c.beqz", 32'h0000_c011, 32'h0004_0263);
		legal_word("c.bnez neg", 32'h0000_fc75, 32'hfe04_1ee3);
	endtask

	// all on x8
	task automatic test_zcb;
		legal_word("c.zext.b", 32'h0000_9c61, 32'h0ff4_7413);
		legal_word("c.sext.b", 32'h0000_9c65, 32'h6044_1413);
		legal_word("c.zext.h", 32'h0000_9c69, 32'h0804_4433);
		legal_word("c.sext.h", 32'h0000_9c6d, 32'h6054_1413);
		legal_word("c.not", 32'h0000_9c75, 32'hfff4_4413);
	endtask

	task automatic test_illegal;
		illegal_word("all zero half", 32'h0000_0000);
		illegal_word("c.flw", 32'h0000_6000);
		illegal_word("c.fsw", 32'h0000_e000);
		illegal_word("c.ld", 32'h0000_6104);
		illegal_word("c.subw", 32'h0000_9c05);
		illegal_word("c.addw", 32'h0000_9c25);
		illegal_word("c.zext.w", 32'h0000_9c71);
		illegal_word("c.lbu", 32'h0000_8004);
		illegal_word("reserved alu", 32'h0000_9c45);
		illegal_word("zcb unused 110", 32'h0000_9c79);
		illegal_word("zcb unused 111", 32'h0000_9c7d);
		illegal_word("c.jr x0", 32'h0000_8002);
	endtask

	initial begin
		clk_i = 1'b0;
		reset_i = 1'b1;
		valid_i = 1'b0;
		instr_i = '0;
		error_count = 0;
		timeout_count = 0;
		seed = 11;
		repeat (10) @(negedge clk_i);
		reset_i = 1'b0;
		test_reset();
		test_strobe_timing();
		test_passthrough();
		test_q0_q2();
		test_q1();
		test_zcb();
		test_illegal();
		repeat (2) @(negedge clk_i);
		$display("errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+design
design/rvc_pkg.sv
design/rvc_quadrant0_decode.sv
design/rvc_quadrant1_decode.sv
design/rvc_quadrant2_decode.sv
design/rvc_format_encoder.sv
design/rvc_decompressor.sv
testbench/rvc_decompressor_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the RVC decompressor testbench with Verilator, runs it and
# scans the log for the failure message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
	--top-module rvc_decompressor_tb -o rvc_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rvc_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log \
	&& { echo "RESULT: FAIL"; exit 1; } \
	|| { echo "RESULT: PASS"; exit 0; }
